// ==== source/ahb_pkg.sv ====
//----------------------------------------------------------------------------
// AHB protocol encodings and bus field types used across the input stage
//----------------------------------------------------------------------------
`default_nettype none

package ahb_pkg;

  localparam int ADDR_W = 32;                // Address bus width

  typedef logic [ADDR_W-1:0] haddr_t;        // HADDR
  typedef logic [2:0]        hsize_t;        // Bytes per beat is 2**HSIZE
  typedef logic [3:0]        hprot_t;        // Protection control

  // HTRANS transfer type
  typedef enum logic [1:0] {
    TRN_IDLE   = 2'b00,                      // No transfer
    TRN_BUSY   = 2'b01,                      // Master inserts a wait in a burst
    TRN_NONSEQ = 2'b10,                      // First or single beat
    TRN_SEQ    = 2'b11                       // Following beat of a burst
  } htrans_t;

  // HBURST burst type
  typedef enum logic [2:0] {
    BUR_SINGLE = 3'b000,
    BUR_INCR   = 3'b001,                     // Undefined length incrementing
    BUR_WRAP4  = 3'b010,
    BUR_INCR4  = 3'b011,
    BUR_WRAP8  = 3'b100,
    BUR_INCR8  = 3'b101,
    BUR_WRAP16 = 3'b110,
    BUR_INCR16 = 3'b111
  } hburst_t;

  // HRESP response, RETRY and SPLIT not carried
  typedef enum logic [1:0] {
    RSP_OKAY  = 2'b00,
    RSP_ERROR = 2'b01
  } hresp_t;

endpackage : ahb_pkg

`default_nettype wire

// ==== source/bm_input_pkg.sv ====
//----------------------------------------------------------------------------
// Bus matrix input stage constants for wrapping burst boundary checks
//----------------------------------------------------------------------------
`default_nettype none

package bm_input_pkg;

  localparam int BEAT_W = 4;                 // Beat offset width for 16 beats

  typedef logic [BEAT_W-1:0] beat_t;         // Beat offset inside a burst

  // Largest HSIZE that scales the offset (64 bit beats)
  // Wider beats fall back to the byte offset
  localparam int MAX_SIZE_SHIFT = 3;

  // All ones offset is the last beat before the wrap point
  localparam beat_t BEAT_LAST = {BEAT_W{1'b1}};

endpackage : bm_input_pkg

`default_nettype wire

// ==== source/input_hold.sv ====
//----------------------------------------------------------------------------
// Input stage holding register. Captures an address phase the output stage
// cannot take and replays it as NONSEQ once this port is granted
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module input_hold
  import ahb_pkg::*;
(
  input  wire          HCLK,
  input  wire          HRESETn,
  input  wire          HSELS,         // Port select from master
  input  wire haddr_t  HADDRS,
  input  wire htrans_t HTRANSS,
  input  wire          HWRITES,
  input  wire hsize_t  HSIZES,
  input  wire hburst_t HBURSTS,
  input  wire hprot_t  HPROTS,
  input  wire          HREADYS,       // Matrix wide HREADY
  input  wire          active_ip,     // Output stage owns the slave for us
  input  wire          readyout_ip,   // HREADYOUT of the shared slave
  output logic         sel_ip,
  output haddr_t       addr_ip,
  output logic         write_ip,
  output hsize_t       size_ip,
  output hprot_t       prot_ip,
  output htrans_t      trans_pre,     // HTRANS ahead of burst fixup
  output hburst_t      burst_pre,     // HBURST ahead of burst fixup
  output htrans_t      trans_sel,     // Live or held HTRANS
  output logic         hold_start,    // Accepted while output stage busy
  output logic         pending,       // Held transfer waiting for grant
  output logic         held_tran_ip   // Request level to the arbiter
);

  logic    load_reg;                  // Address phase accepted this edge
  logic    pending_next;
  htrans_t reg_trans;                 // Captured address phase
  haddr_t  reg_addr;
  logic    reg_write;
  hsize_t  reg_size;
  hburst_t reg_burst;
  hprot_t  reg_prot;

  // NONSEQ or SEQ to this port with HREADY high
  assign load_reg   = HSELS & HTRANSS[1] & HREADYS;
  assign hold_start = load_reg & ~active_ip;

  //--------------------------------------------------------------------------
  // Holding register
  //--------------------------------------------------------------------------
  // Loaded on every accepted beat, only read back while pending
  always_ff @(posedge HCLK)
  begin
    if (load_reg)
    begin
      reg_trans <= HTRANSS;
      reg_addr  <= HADDRS;
      reg_write <= HWRITES;
      reg_size  <= HSIZES;
      reg_burst <= HBURSTS;
      reg_prot  <= HPROTS;
    end
  end

  //--------------------------------------------------------------------------
  // Pending flag and request
  //--------------------------------------------------------------------------
  always_comb
  begin
    pending_next = pending;
    if (hold_start)
      pending_next = 1'b1;              // Output stage could not take it
    else if (active_ip && readyout_ip)
      pending_next = 1'b0;              // Replay went out to the slave
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pending <= 1'b0;
    else
      pending <= pending_next;
  end

  assign held_tran_ip = load_reg | pending;   // Live beat or held beat

  //--------------------------------------------------------------------------
  // Replay mux
  //--------------------------------------------------------------------------
  always_comb
  begin
    if (pending)
    begin
      sel_ip    = 1'b1;                 // Held beat always targets us
      trans_pre = TRN_NONSEQ;           // Replay restarts the burst
      addr_ip   = reg_addr;
      write_ip  = reg_write;
      size_ip   = reg_size;
      burst_pre = reg_burst;
      prot_ip   = reg_prot;
      trans_sel = reg_trans;
    end
    else
    begin
      sel_ip    = HSELS;                // Straight through path
      trans_pre = HTRANSS;
      addr_ip   = HADDRS;
      write_ip  = HWRITES;
      size_ip   = HSIZES;
      burst_pre = HBURSTS;
      prot_ip   = HPROTS;
      trans_sel = HTRANSS;
    end
  end

endmodule : input_hold

`default_nettype wire

// ==== source/wrap_bound.sv ====
//----------------------------------------------------------------------------
// Wrap boundary detect. Flags the beat that is last before a wrapping
// burst returns to the start of its address window
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wrap_bound
  import ahb_pkg::*, bm_input_pkg::*;
(
  input  wire          HCLK,
  input  wire          HRESETn,
  input  wire haddr_t  HADDRS,
  input  wire htrans_t HTRANSS,
  input  wire hsize_t  HSIZES,
  input  wire hburst_t HBURSTS,
  input  wire          HREADYS,
  output logic         bound          // Previous beat sat on the boundary
);

  beat_t offset;                      // Beat index inside the window
  beat_t check_beat;                  // Offset with out of window bits set
  logic  bound_next;
  logic  bound_en;

  // Scale the byte address into a beat index
  assign offset = (HSIZES <= hsize_t'(MAX_SIZE_SHIFT)) ? beat_t'(HADDRS >> HSIZES)
                                                       : HADDRS[BEAT_W-1:0];

  always_comb
  begin
    case (HBURSTS)
      BUR_WRAP4:  check_beat = offset | beat_t'(4'b1100);   // Window of 4
      BUR_WRAP8:  check_beat = offset | beat_t'(4'b1000);   // Window of 8
      BUR_WRAP16: check_beat = offset;
      default:    check_beat = '0;                          // Never wraps
    endcase
  end

  assign bound_next = (check_beat == BEAT_LAST);
  assign bound_en   = HTRANSS[1] & HREADYS;   // Active beat accepted

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      bound <= 1'b0;
    else if (bound_en)
      bound <= bound_next;
  end

endmodule : wrap_bound

`default_nettype wire

// ==== source/burst_fixup.sv ====
//----------------------------------------------------------------------------
// Early burst termination. Rewrites HTRANS and HBURST so that a burst cut
// short by a hold still reaches the slave as legal AHB
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module burst_fixup
  import ahb_pkg::*;
(
  input  wire          HCLK,
  input  wire          HRESETn,
  input  wire htrans_t HTRANSS,
  input  wire haddr_t  HADDRS,
  input  wire hsize_t  HSIZES,
  input  wire hburst_t HBURSTS,
  input  wire          HREADYS,
  input  wire          hold_start,    // Beat held while output stage busy
  input  wire htrans_t trans_pre,
  input  wire hburst_t burst_pre,
  input  wire htrans_t trans_sel,
  output htrans_t      trans_ip,
  output hburst_t      burst_ip
);

  logic override;                     // Remainder of burst runs as INCR
  logic override_next;
  logic bound;                        // Wrap point crossed last beat

  wrap_bound u_wrap_bound (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .HADDRS  (HADDRS),
    .HTRANSS (HTRANSS),
    .HSIZES  (HSIZES),
    .HBURSTS (HBURSTS),
    .HREADYS (HREADYS),
    .bound   (bound)
  );

  always_comb
  begin
    override_next = override;
    if ((HTRANSS == TRN_NONSEQ) || (HTRANSS == TRN_IDLE))
      override_next = 1'b0;               // New burst or bus idle
    else if ((HTRANSS == TRN_SEQ) && hold_start)
      override_next = 1'b1;               // Burst broken by the hold
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      override <= 1'b0;
    else if (HREADYS)
      override <= override_next;
  end

  // SEQ to NONSEQ and BUSY to IDLE past the wrap point
  assign trans_ip = (override && bound) ? htrans_t'({trans_pre[1], 1'b0}) : trans_pre;

  // Replayed NONSEQ keeps its burst type
  assign burst_ip = (override && (trans_sel != TRN_NONSEQ)) ? BUR_INCR : burst_pre;

endmodule : burst_fixup

`default_nettype wire

// ==== source/resp_mux.sv ====
//----------------------------------------------------------------------------
// Response mux. Picks the HREADYOUT and HRESP source seen by the master
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module resp_mux
  import ahb_pkg::*;
(
  input  wire          HCLK,
  input  wire          HRESETn,
  input  wire          HSELS,
  input  wire htrans_t HTRANSS,
  input  wire          HREADYS,
  input  wire          pending,       // Held transfer stalls the master
  input  wire          readyout_ip,   // Shared slave HREADYOUT
  input  wire hresp_t  resp_ip,       // Shared slave HRESP
  output logic         HREADYOUTS,
  output hresp_t       HRESPS
);

  logic addr_valid;                   // Active beat to this port
  logic data_valid;                   // Data phase owed a real response

  assign addr_valid = HSELS & HTRANSS[1];

  // Data phase follows the accepted address phase
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid <= 1'b0;
    else if (HREADYS)
      data_valid <= addr_valid;
  end

  always_comb
  begin
    if (!data_valid)
    begin
      HREADYOUTS = 1'b1;              // IDLE, BUSY or not selected
      HRESPS     = RSP_OKAY;
    end
    else if (pending)
    begin
      HREADYOUTS = 1'b0;              // Wait until replay completes
      HRESPS     = RSP_OKAY;
    end
    else
    begin
      HREADYOUTS = readyout_ip;       // Forward from the slave
      HRESPS     = resp_ip;
    end
  end

endmodule : resp_mux

`default_nettype wire

// ==== source/ahb_input_stage.sv ====
//----------------------------------------------------------------------------
// AHB bus matrix input stage. Holds, replays and repairs transfers from
// one master port and returns the slave response
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ahb_input_stage
  import ahb_pkg::*;
(
  input  wire          HCLK,
  input  wire          HRESETn,
  // Master port address and control
  input  wire          HSELS,
  input  wire haddr_t  HADDRS,
  input  wire htrans_t HTRANSS,
  input  wire          HWRITES,
  input  wire hsize_t  HSIZES,
  input  wire hburst_t HBURSTS,
  input  wire hprot_t  HPROTS,
  input  wire          HREADYS,
  // Output stage response
  input  wire          active_ip,
  input  wire          readyout_ip,
  input  wire hresp_t  resp_ip,
  // Master port response
  output logic         HREADYOUTS,
  output hresp_t       HRESPS,
  // Towards the output stages
  output logic         sel_ip,
  output haddr_t       addr_ip,
  output htrans_t      trans_ip,
  output logic         write_ip,
  output hsize_t       size_ip,
  output hburst_t      burst_ip,
  output hprot_t       prot_ip,
  output logic         held_tran_ip
);

  logic    pending;
  logic    hold_start;
  htrans_t trans_pre;
  hburst_t burst_pre;
  htrans_t trans_sel;

  input_hold u_input_hold (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .HSELS        (HSELS),
    .HADDRS       (HADDRS),
    .HTRANSS      (HTRANSS),
    .HWRITES      (HWRITES),
    .HSIZES       (HSIZES),
    .HBURSTS      (HBURSTS),
    .HPROTS       (HPROTS),
    .HREADYS      (HREADYS),
    .active_ip    (active_ip),
    .readyout_ip  (readyout_ip),
    .sel_ip       (sel_ip),
    .addr_ip      (addr_ip),
    .write_ip     (write_ip),
    .size_ip      (size_ip),
    .prot_ip      (prot_ip),
    .trans_pre    (trans_pre),
    .burst_pre    (burst_pre),
    .trans_sel    (trans_sel),
    .hold_start   (hold_start),
    .pending      (pending),
    .held_tran_ip (held_tran_ip)
  );

  burst_fixup u_burst_fixup (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .HTRANSS    (HTRANSS),
    .HADDRS     (HADDRS),
    .HSIZES     (HSIZES),
    .HBURSTS    (HBURSTS),
    .HREADYS    (HREADYS),
    .hold_start (hold_start),
    .trans_pre  (trans_pre),
    .burst_pre  (burst_pre),
    .trans_sel  (trans_sel),
    .trans_ip   (trans_ip),
    .burst_ip   (burst_ip)
  );

  resp_mux u_resp_mux (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .HSELS       (HSELS),
    .HTRANSS     (HTRANSS),
    .HREADYS     (HREADYS),
    .pending     (pending),
    .readyout_ip (readyout_ip),
    .resp_ip     (resp_ip),
    .HREADYOUTS  (HREADYOUTS),
    .HRESPS      (HRESPS)
  );

endmodule : ahb_input_stage

`default_nettype wire

// ==== verification/ahb_input_stage_assert.sv ====
//----------------------------------------------------------------------------
// Concurrent checks on hold and response behaviour of the input stage
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ahb_input_stage_assert
  import ahb_pkg::*;
(
  input wire          HCLK,
  input wire          HRESETn,
  input wire          active_ip,
  input wire          readyout_ip,
  input wire          pending,
  input wire          HREADYOUTS,
  input wire          held_tran_ip,
  input wire          sel_ip,
  input wire htrans_t trans_ip       // Transfer type after burst fixup
);

  // Data phase of the held beat stalls the master
  a_pending_stall: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $rose(pending) |-> !HREADYOUTS)
    else $error("HREADYOUTS high in the data phase of a held transfer");

  // Request stays up until the output stage completes the replay
  a_request_level: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (pending && !(active_ip && readyout_ip)) |=> held_tran_ip)
    else $error("held_tran_ip dropped before the held transfer completed");

  // Replay must reach the slave as a real transfer
  a_replay_active: assert property (@(posedge HCLK) disable iff (!HRESETn)
    pending |-> (sel_ip && (trans_ip != TRN_IDLE)))
    else $error("Held replay without select or with an IDLE transfer");

endmodule : ahb_input_stage_assert

// Hold, burst repair and response select all meet at the stage top level
bind ahb_input_stage ahb_input_stage_assert u_stage_assert (
  .HCLK         (HCLK),
  .HRESETn      (HRESETn),
  .active_ip    (active_ip),
  .readyout_ip  (readyout_ip),
  .pending      (pending),
  .HREADYOUTS   (HREADYOUTS),
  .held_tran_ip (held_tran_ip),
  .sel_ip       (sel_ip),
  .trans_ip     (trans_ip)
);

`default_nettype wire

// ==== verification/ahb_input_stage_tb.sv ====
//----------------------------------------------------------------------------
// Testbench for the AHB input stage. LCG stimulus checked every cycle
// against a reference model of hold, replay, burst repair and responses
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ahb_input_stage_tb
  import ahb_pkg::*, bm_input_pkg::*;
();

  logic    clk;
  logic    HRESETn;
  logic    HSELS;
  haddr_t  HADDRS;
  htrans_t HTRANSS;
  logic    HWRITES;
  hsize_t  HSIZES;
  hburst_t HBURSTS;
  hprot_t  HPROTS;
  logic    HREADYS;
  logic    active_ip;
  logic    readyout_ip;
  hresp_t  resp_ip;
  logic    HREADYOUTS;
  hresp_t  HRESPS;
  logic    sel_ip;
  haddr_t  addr_ip;
  htrans_t trans_ip;
  logic    write_ip;
  hsize_t  size_ip;
  hburst_t burst_ip;
  hprot_t  prot_ip;
  logic    held_tran_ip;

  // Reference model state
  logic    m_pending;
  logic    m_valid;
  logic    m_bound;
  logic    m_override;
  htrans_t m_trans;
  haddr_t  m_addr;
  logic    m_write;
  hsize_t  m_size;
  hburst_t m_burst;
  hprot_t  m_prot;

  // Expected outputs for the current cycle
  logic    e_sel;
  logic    e_write;
  logic    e_held;
  logic    e_ready;
  haddr_t  e_addr;
  htrans_t e_trans;
  hsize_t  e_size;
  hburst_t e_burst;
  hprot_t  e_prot;
  hresp_t  e_resp;

  logic        checking    = 1'b0;    // Set once reset is released
  logic [31:0] lcg_state   = 32'h809c_24dd;
  int          err_count   = 0;       // Wrong values from the compare process
  int          fail_count  = 0;       // Timeouts and protocol misses
  int          check_count = 0;
  int          test_num    = 0;
  int          test_base   = 0;
  int          incr_seen   = 0;       // Bursts forced to INCR
  int          cut_seen    = 0;       // SEQ beats turned into NONSEQ

  ahb_input_stage UUT (
    .HCLK (clk),
    .*
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;            // 8 ns period
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  //--------------------------------------------------------------------------
  // Reference model called once per cycle
  //--------------------------------------------------------------------------
  function automatic void ref_stage();
    logic    active_beat;
    logic    accept;
    logic    hold;
    htrans_t t_pre;
    htrans_t t_sel;
    hburst_t b_pre;
    int      beat;
    int      span;
    active_beat = (HTRANSS == TRN_NONSEQ) || (HTRANSS == TRN_SEQ);
    accept      = HSELS && active_beat && HREADYS;
    hold        = accept && !active_ip;   // Output stage busy elsewhere
    if (m_pending)
    begin
      e_sel   = 1'b1;                     // Held beat replayed as NONSEQ
      e_addr  = m_addr;
      e_write = m_write;
      e_size  = m_size;
      e_prot  = m_prot;
      t_pre   = TRN_NONSEQ;
      t_sel   = m_trans;
      b_pre   = m_burst;
    end
    else
    begin
      e_sel   = HSELS;
      e_addr  = HADDRS;
      e_write = HWRITES;
      e_size  = HSIZES;
      e_prot  = HPROTS;
      t_pre   = HTRANSS;
      t_sel   = HTRANSS;
      b_pre   = HBURSTS;
    end
    e_trans = t_pre;
    if (m_override && m_bound && (t_pre == TRN_SEQ))
      e_trans = TRN_NONSEQ;               // Past the wrap point
    if (m_override && m_bound && (t_pre == TRN_BUSY))
      e_trans = TRN_IDLE;
    e_burst = (m_override && (t_sel != TRN_NONSEQ)) ? BUR_INCR : b_pre;
    e_held  = accept || m_pending;
    e_ready = 1'b1;
    e_resp  = RSP_OKAY;
    if (m_valid && m_pending)
      e_ready = 1'b0;
    else if (m_valid)
    begin
      e_ready = readyout_ip;
      e_resp  = resp_ip;
    end
    if ((e_burst == BUR_INCR) && (b_pre != BUR_INCR))
      incr_seen++;
    if ((t_pre == TRN_SEQ) && (e_trans == TRN_NONSEQ))
      cut_seen++;
    // Next state
    if (accept)
    begin
      m_trans = HTRANSS;
      m_addr  = HADDRS;
      m_write = HWRITES;
      m_size  = HSIZES;
      m_burst = HBURSTS;
      m_prot  = HPROTS;
    end
    if (!HRESETn)
    begin
      m_pending  = 1'b0;
      m_valid    = 1'b0;
      m_bound    = 1'b0;
      m_override = 1'b0;
    end
    else
    begin
      if (hold)
        m_pending = 1'b1;
      else if (active_ip && readyout_ip)
        m_pending = 1'b0;
      if (HREADYS)
        m_valid = HSELS && active_beat;
      if (active_beat && HREADYS)
      begin
        case (HBURSTS)
          BUR_WRAP4:  span = 4;
          BUR_WRAP8:  span = 8;
          BUR_WRAP16: span = 16;
          default:    span = 0;
        endcase
        // Beat index from address and size or byte index for wide beats
        if (int'(HSIZES) <= MAX_SIZE_SHIFT)
          beat = int'(HADDRS[7:0] >> HSIZES) % 16;
        else
          beat = int'(HADDRS[3:0]);
        m_bound = (span != 0) && ((beat % span) == (span - 1));
      end
      if (HREADYS && ((HTRANSS == TRN_NONSEQ) || (HTRANSS == TRN_IDLE)))
        m_override = 1'b0;
      else if (HREADYS && (HTRANSS == TRN_SEQ) && hold)
        m_override = 1'b1;
    end
  endfunction

  //--------------------------------------------------------------------------
  // Compare tasks
  //--------------------------------------------------------------------------
  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_addr(input string name, input haddr_t got, input haddr_t exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_trans(input string name, input htrans_t got, input htrans_t exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_burst(input string name, input hburst_t got, input hburst_t exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_size(input string name, input hsize_t got, input hsize_t exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_prot(input string name, input hprot_t got, input hprot_t exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_resp(input string name, input hresp_t got, input hresp_t exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // Outputs settle by the falling edge
  always @(negedge clk)
  begin
    ref_stage();
    if (checking)
    begin
      check_bit("sel_ip", sel_ip, e_sel);
      check_addr("addr_ip", addr_ip, e_addr);
      check_trans("trans_ip", trans_ip, e_trans);
      check_bit("write_ip", write_ip, e_write);
      check_size("size_ip", size_ip, e_size);
      check_burst("burst_ip", burst_ip, e_burst);
      check_prot("prot_ip", prot_ip, e_prot);
      check_bit("held_tran_ip", held_tran_ip, e_held);
      check_bit("HREADYOUTS", HREADYOUTS, e_ready);
      check_resp("HRESPS", HRESPS, e_resp);
    end
  end

  //--------------------------------------------------------------------------
  // Stimulus helpers
  //--------------------------------------------------------------------------
  task automatic drive(input logic sel, input htrans_t trans, input haddr_t addr,
                       input hsize_t size, input hburst_t burst, input logic ready,
                       input logic act, input logic rdy);
    logic [31:0] r;
    r = next_rand();
    @(posedge clk);
    HSELS       <= sel;
    HTRANSS     <= trans;
    HADDRS      <= addr;
    HSIZES      <= size;
    HBURSTS     <= burst;
    HREADYS     <= ready;
    active_ip   <= act;
    readyout_ip <= rdy;
    HWRITES     <= r[0];              // Don't care fields from the LCG
    HPROTS      <= r[4:1];
    resp_ip     <= hresp_t'({1'b0, r[5]});
  endtask

  task automatic end_test(input string name);
    int errs;
    drive(1'b0, TRN_IDLE, '0, 3'd0, BUR_SINGLE, 1'b1, 1'b1, 1'b1);
    @(posedge clk);                   // Idle cycle compared before the tally
    errs = err_count + fail_count - test_base;
    test_num++;
    $display("test %0d %s: %s (%0d errors)", test_num, name,
             (errs == 0) ? "ok" : "failed", errs);
    test_base = err_count + fail_count;
  endtask

  // Single beat held until granted after grant_delay and ready slave_wait later
  task automatic replay_held_beat(input int grant_delay, input int slave_wait);
    haddr_t a;
    int     n;
    logic   done;
    a = haddr_t'(next_rand()) & 32'hFFFF_FFFC;
    drive(1'b1, TRN_NONSEQ, a, 3'd2, BUR_INCR, 1'b1, 1'b0, 1'b1);
    n    = 0;
    done = 1'b0;
    while (!done && (n < 40))
    begin
      // Master stalled with its next beat on the bus
      drive(1'b1, TRN_NONSEQ, a + 32'd4, 3'd2, BUR_INCR, 1'b0,
            n >= grant_delay, n >= grant_delay + slave_wait);
      @(negedge clk);
      if (!held_tran_ip)
        done = 1'b1;
      else
        n++;
    end
    if (!done)
    begin
      fail_count++;
      $display("Timeout waiting for the held transfer to complete at %0t", $time);
    end
    else if (n != grant_delay + slave_wait + 1)
    begin
      fail_count++;
      $display("Hold did not end one cycle after the grant at %0t", $time);
    end
    drive(1'b1, TRN_NONSEQ, a + 32'd4, 3'd2, BUR_INCR, 1'b1, 1'b1, 1'b1);
  endtask

  // Wrapping burst held on its boundary beat
  task automatic cut_wrap_burst(input hburst_t burst, input hsize_t size,
                                input haddr_t base);
    int     span;
    haddr_t step;
    span = (burst == BUR_WRAP4) ? 4 : 8;
    step = haddr_t'(1) << size;
    drive(1'b1, TRN_NONSEQ, base + step * haddr_t'(span - 2), size, burst, 1'b1, 1'b1, 1'b1);
    drive(1'b1, TRN_SEQ, base + step * haddr_t'(span - 1), size, burst, 1'b1, 1'b0, 1'b1);
    drive(1'b1, TRN_SEQ, base, size, burst, 1'b0, 1'b1, 1'b1);   // Replay granted
    drive(1'b1, TRN_SEQ, base, size, burst, 1'b1, 1'b1, 1'b1);   // First beat past wrap
    drive(1'b1, TRN_SEQ, base + step, size, burst, 1'b1, 1'b1, 1'b1);
  endtask

  //--------------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------------
  initial
  begin
    logic [31:0] r;
    int          i;
    int          base_incr;
    int          base_cut;
    HRESETn     <= 1'b0;
    HSELS       <= 1'b0;
    HADDRS      <= '0;
    HTRANSS     <= TRN_IDLE;
    HWRITES     <= 1'b0;
    HSIZES      <= 3'd0;
    HBURSTS     <= BUR_SINGLE;
    HPROTS      <= 4'h0;
    HREADYS     <= 1'b1;
    active_ip   <= 1'b0;
    readyout_ip <= 1'b1;
    resp_ip     <= RSP_OKAY;
    repeat (2) @(posedge clk);
    HRESETn  <= 1'b1;
    checking = 1'b1;
    end_test("values after reset");

    repeat (40)
    begin
      r = next_rand();
      drive(r[0] | r[1], htrans_t'(r[3:2]), haddr_t'(next_rand()), hsize_t'(r[6:4]),
            hburst_t'(r[9:7]), r[10] | r[11], 1'b1, 1'b1);
    end
    end_test("address path with output stage free");

    for (i = 0; i < 6; i++)
    begin
      r = next_rand();
      replay_held_beat(int'(r[1:0]), 0);
    end
    end_test("hold and replay");

    for (i = 0; i < 6; i++)
    begin
      r = next_rand();
      replay_held_beat(int'(r[1:0]), 1 + int'(r[3:2]));
    end
    repeat (20)
    begin
      r = next_rand();
      drive(1'b1, htrans_t'({1'b1, r[0]}), haddr_t'(next_rand()), 3'd2,
            BUR_INCR, r[1] | r[2], 1'b1, r[3]);
    end
    end_test("hold release and response return");

    repeat (40)
    begin
      r = next_rand();
      drive(r[0] & r[1], htrans_t'({r[2] & r[3], r[4]}), haddr_t'(next_rand()),
            hsize_t'(r[7:5]), hburst_t'(r[10:8]), r[11] | r[12], 1'b1, r[13]);
    end
    end_test("idle, busy and unselected data phases");

    base_incr = incr_seen;
    base_cut  = cut_seen;
    cut_wrap_burst(BUR_WRAP4, 3'd2, 32'h0000_1000);
    cut_wrap_burst(BUR_WRAP8, 3'd1, 32'h0000_2040);
    if ((incr_seen == base_incr) || (cut_seen < base_cut + 2))
    begin
      fail_count++;
      $display("Wrap burst repair was not exercised by the held bursts");
    end
    end_test("wrapping bursts cut by a hold");

    $display("tests %0d, checks %0d, errors %0d", test_num, check_count,
             err_count + fail_count);
    if (err_count + fail_count == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule : ahb_input_stage_tb

`default_nettype wire

// ==== ahb_input_stage.f ====
source/ahb_pkg.sv
source/bm_input_pkg.sv
source/input_hold.sv
source/wrap_bound.sv
source/burst_fixup.sv
source/resp_mux.sv
source/ahb_input_stage.sv
verification/ahb_input_stage_assert.sv
verification/ahb_input_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= ahb_input_stage_tb
FILELIST  ?= ahb_input_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG) || ! grep -q "=== PASS ===" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
